//--- project.f
ttc_pkg.sv
ttc_wb_regs.sv
ttc_prescaler.sv
ttc_counter.sv
ttc_intr_ctrl.sv
ttc_timer_top.sv
tb_clock_gen.sv
tb_ttc_timer.sv

//--- run.sh
#!/bin/sh
# Build and run the timer channel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ttc_timer -f project.f -o tb_ttc_timer

./obj_dir/tb_ttc_timer | tee sim.log

# Pass only if the testbench printed its pass line
grep -q 'All tests passed!' sim.log
echo "Simulation passed"

//--- tb_ttc_timer.sv
//----------------------------------------------------------------------
// Testbench top for one timer channel on Wishbone classic.
// Inputs change 5 ns after the rising edge and outputs are sampled on falling.
// Overflow test runs a full 16-bit count of about 66k cycles.
//----------------------------------------------------------------------
module tb_ttc_timer;
  timeunit 1ns;
  timeprecision 100ps;

  import ttc_pkg::*;

  localparam int OVF_CYCLES     = 70_000;   // 2^16 counts plus margin
  localparam int TIMEOUT_CYCLES = 200_000;  // Overflow test dominates
  localparam int ACK_LIMIT      = 16;

  logic             pclk11;
  logic             n_p_reset11;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [ADR_W-1:0] wb_adr;
  logic [CNT_W-1:0] wb_dat_i;
  logic [CNT_W-1:0] wb_dat_o;
  logic             wb_ack;
  logic             irq;
  logic             irq_quiet = 1'b0;  // irq must stay low while set
  int               cycles = 0;
  int               ack_cycle = 0;     // Cycle stamp of the last ack
  int               val_errs = 0;
  int               assert_errs = 0;
  int               wait_errs = 0;

  tb_clock_gen clock_gen_inst (
    .pclk11      (pclk11),
    .n_p_reset11 (n_p_reset11)
  );

  ttc_timer_top ttc_timer_top_inst (
    .pclk11      (pclk11),
    .n_p_reset11 (n_p_reset11),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack      (wb_ack),
    .irq         (irq)
  );

  //--------------------------------------------------------------------
  // Bus and wait helpers
  //--------------------------------------------------------------------
  task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr,
                           input logic [CNT_W-1:0] wdata,
                           output logic [CNT_W-1:0] rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(posedge pclk11);
    #5;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = wdata;
    @(negedge pclk11);
    while (!wb_ack && waited < ACK_LIMIT)
    begin
      waited++;
      @(negedge pclk11);
    end
    if (wb_ack)
    begin
      rdata     = wb_dat_o;            // Registered and stable in ack cycle
      ack_cycle = cycles;
    end
    else
    begin
      wait_errs++;
      $display("No ack at %0t for address %0d", $time, adr);
    end
    @(posedge pclk11);                 // Edge that ends the ack cycle
    #5;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [CNT_W-1:0] data);
    logic [CNT_W-1:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [CNT_W-1:0] data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic read_expect(input logic [ADR_W-1:0] adr, input string name,
                             input logic [CNT_W-1:0] exp, input logic [CNT_W-1:0] mask);
    logic [CNT_W-1:0] data;
    wb_read(adr, data);
    if ((data & mask) !== exp)
    begin
      val_errs++;
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, data & mask);
    end
  endtask

  // Count must stay inside the interval range
  task automatic read_at_most(input logic [CNT_W-1:0] limit);
    logic [CNT_W-1:0] data;
    wb_read(COUNT, data);
    if (data > limit)
    begin
      val_errs++;
      $display("mismatch at %0t: COUNT expected <= %0d, got %0d", $time, limit, data);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge pclk11);
  endtask

  // Poll the ISR until every mask bit has been seen
  task automatic wait_isr_bits(input logic [CNT_W-1:0] mask, input int limit);
    logic [CNT_W-1:0] data;
    logic [CNT_W-1:0] seen;
    int               start;
    seen  = '0;
    start = cycles;
    while ((seen & mask) != mask && cycles - start < limit)
    begin
      wb_read(ISR, data);
      seen = seen | data;
    end
    if ((seen & mask) != mask)
    begin
      wait_errs++;
      $display("ISR bits %h never set within %0d cycles", mask, limit);
    end
  endtask

  task automatic wait_irq(input int limit);
    int waited;
    waited = 0;
    @(negedge pclk11);
    while (!irq && waited < limit)
    begin
      waited++;
      @(negedge pclk11);
    end
    if (!irq)
    begin
      wait_errs++;
      $display("irq did not rise within %0d cycles", limit);
    end
  endtask

  // Disable and flush the ISR so the second read is empty
  task automatic stop_and_clear();
    logic [CNT_W-1:0] data;
    wb_write(CNT_CTRL, 16'h0001);
    wb_read(ISR, data);
    read_expect(ISR, "ISR", 16'h0000, 16'hffff);
  endtask

  //--------------------------------------------------------------------
  // Checking assertions
  //--------------------------------------------------------------------
  a_ack_req: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
    wb_ack |-> (wb_cyc && wb_stb))
    else
    begin
      assert_errs++;
      $display("Ack at %0t without a held request", $time);
    end

  a_ack_pulse: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
    wb_ack |=> !wb_ack)
    else
    begin
      assert_errs++;
      $display("Ack held for two cycles at %0t", $time);
    end

  a_unmapped: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
    (wb_ack && !wb_we && wb_adr > 4'd8) |-> (wb_dat_o == '0))
    else
    begin
      assert_errs++;
      $display("mismatch at %0t: wb_dat_o expected 0000, got %h", $time, wb_dat_o);
    end

  a_irq_quiet: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
    irq_quiet |-> !irq)
    else
    begin
      assert_errs++;
      $display("mismatch at %0t: irq expected 0, got %b", $time, irq);
    end

  // Run limit
  always @(posedge pclk11)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, run did not complete", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------
  initial
  begin
    logic [CNT_W-1:0] c0;
    logic [CNT_W-1:0] c1;
    int               t0;
    int               n;
    int               diff;
    int               exp_steps;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    @(posedge n_p_reset11);
    wait_cycles(2);

    // 1. Reset values, readback, unmapped and restart self clear
    read_expect(CNT_CTRL, "CNT_CTRL", 16'h0001, 16'hffff);
    read_expect(COUNT, "COUNT", 16'h0000, 16'hffff);
    wb_write(INTERVAL, 16'ha5c3);
    read_expect(INTERVAL, "INTERVAL", 16'ha5c3, 16'hffff);
    wb_write(MATCH1, 16'h1234);
    read_expect(MATCH1, "MATCH1", 16'h1234, 16'hffff);
    wb_write(MATCH2, 16'hfedc);
    read_expect(MATCH2, "MATCH2", 16'hfedc, 16'hffff);
    wb_write(MATCH3, 16'h0f0f);
    read_expect(MATCH3, "MATCH3", 16'h0f0f, 16'hffff);
    wb_write(IER, 16'h0015);
    read_expect(IER, "IER", 16'h0015, 16'hffff);
    wb_write(CLK_CTRL, 16'h001b);
    read_expect(CLK_CTRL, "CLK_CTRL", 16'h001b, 16'hffff);
    wb_write(IER, 16'h0000);
    wb_write(CLK_CTRL, 16'h0000);
    for (int a = 9; a < 16; a++)
    begin
      wb_write(a[ADR_W-1:0], 16'hffff); // Must be ignored
      read_expect(a[ADR_W-1:0], "unmapped", 16'h0000, 16'hffff);
    end
    wb_write(CNT_CTRL, 16'h0011);      // Restart while disabled
    wait_cycles(4);
    read_expect(CNT_CTRL, "CNT_CTRL", 16'h0001, 16'hffff);

    // 2. Interval increment with wrap at 20
    wb_write(INTERVAL, 16'd20);
    wb_write(CNT_CTRL, 16'h0012);
    repeat (30) read_at_most(16'd20);
    wait_isr_bits(16'h0001, 200);
    wb_write(IER, 16'h0001);
    wait_irq(60);
    stop_and_clear();
    wb_write(IER, 16'h0000);

    // 3. Interval decrement where restart loads the interval
    wb_write(CNT_CTRL, 16'h0017);
    wait_cycles(4);
    read_expect(COUNT, "COUNT", 16'd20, 16'hffff);
    read_expect(CNT_CTRL, "CNT_CTRL", 16'h0007, 16'hffff);
    wb_write(CNT_CTRL, 16'h0006);
    repeat (30) read_at_most(16'd20);
    wait_isr_bits(16'h0001, 200);
    stop_and_clear();

    // 4. Match mode with match 3 out of reach
    wb_write(INTERVAL, 16'd40);
    wb_write(MATCH1, 16'd5);
    wb_write(MATCH2, 16'd9);
    wb_write(MATCH3, 16'h0300);
    wb_write(IER, 16'h0010);           // Only match 3 may raise irq
    wait_cycles(2);
    #5;
    irq_quiet = 1'b1;                  // Away from the clock edge
    wb_write(CNT_CTRL, 16'h001a);
    wait_isr_bits(16'h000c, 300);
    wait_cycles(100);
    read_expect(ISR, "ISR", 16'h0000, 16'h0010);
    stop_and_clear();
    irq_quiet = 1'b0;
    wb_write(IER, 16'h0000);

    // 5. Full-range overflow with all interrupts masked
    wait_cycles(2);
    #5;
    irq_quiet = 1'b1;
    wb_write(CNT_CTRL, 16'h0010);
    wait_isr_bits(16'h0002, OVF_CYCLES);
    stop_and_clear();
    irq_quiet = 1'b0;

    // 6. Prescaler divide by 8
    wb_write(CLK_CTRL, 16'h0005);
    wb_write(CNT_CTRL, 16'h0010);
    wait_cycles(20);
    wb_read(COUNT, c0);
    t0 = ack_cycle;
    wait_cycles(400);
    wb_read(COUNT, c1);
    n         = ack_cycle - t0;
    exp_steps = n / 8;
    diff      = int'(c1 - c0);
    if (diff > exp_steps + 1 || diff + 1 < exp_steps)
    begin
      val_errs++;
      $display("mismatch at %0t: COUNT step expected %0d, got %0d", $time, exp_steps, diff);
    end
    stop_and_clear();
    wb_write(CLK_CTRL, 16'h0000);

    $display("Errors: %0d value, %0d assertion, %0d wait", val_errs, assert_errs, wait_errs);
    if (val_errs + assert_errs + wait_errs == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- tb_clock_gen.sv
//----------------------------------------------------------------------
// Testbench clock and reset, 100 ns period.
// Reset is low for 4 rising edges and released 5 ns after the last one.
//----------------------------------------------------------------------
module tb_clock_gen (
  output logic pclk11,
  output logic n_p_reset11
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 50;

  initial
  begin
    pclk11 = 1'b0;
    forever #HALF_PERIOD pclk11 = ~pclk11;
  end

  initial
  begin
    n_p_reset11 = 1'b0;
    repeat (4) @(posedge pclk11);
    #5;
    n_p_reset11 = 1'b1;                // Away from the clock edge
  end

endmodule

//--- ttc_timer_top.sv
//--------------------------------------------------------------------
// Single timer channel: bus, prescaler, counter, interrupt stage.
// Wishbone classic slave, full-word accesses only.
//--------------------------------------------------------------------
module ttc_timer_top (
  input  logic                       pclk11,
  input  logic                       n_p_reset11,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [ttc_pkg::ADR_W-1:0]  wb_adr,
  input  logic [ttc_pkg::CNT_W-1:0]  wb_dat_i,
  output logic [ttc_pkg::CNT_W-1:0]  wb_dat_o,
  output logic                       wb_ack,
  output logic                       irq
);

  import ttc_pkg::*;

  reg_wr_t   reg_wr;                   // Bus to all stages
  logic      isr_rd_clr;
  clk_ctrl_t clk_ctrl;
  logic      count_en;
  cnt_view_t cnt_view;
  intr_evt_t evt;
  intr_evt_t isr;
  intr_evt_t ier;

  ttc_wb_regs ttc_wb_regs_inst (
    .pclk11      (pclk11),
    .n_p_reset11 (n_p_reset11),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack      (wb_ack),
    .reg_wr      (reg_wr),
    .isr_rd_clr  (isr_rd_clr),
    .cnt_view    (cnt_view),
    .clk_ctrl    (clk_ctrl),
    .isr         (isr),
    .ier         (ier)
  );

  ttc_prescaler ttc_prescaler_inst (
    .pclk11      (pclk11),
    .n_p_reset11 (n_p_reset11),
    .reg_wr      (reg_wr),
    .clk_ctrl    (clk_ctrl),
    .count_en    (count_en)
  );

  ttc_counter ttc_counter_inst (
    .pclk11      (pclk11),
    .n_p_reset11 (n_p_reset11),
    .reg_wr      (reg_wr),
    .count_en    (count_en),
    .cnt_view    (cnt_view),
    .evt         (evt)
  );

  ttc_intr_ctrl ttc_intr_ctrl_inst (
    .pclk11      (pclk11),
    .n_p_reset11 (n_p_reset11),
    .reg_wr      (reg_wr),
    .evt         (evt),
    .isr_rd_clr  (isr_rd_clr),
    .isr         (isr),
    .ier         (ier),
    .irq         (irq)
  );

endmodule

//--- ttc_intr_ctrl.sv
//--------------------------------------------------------------------
// Sticky interrupt status with enable mask and clear on read.
// Only bits returned by the read are cleared; new events still set.
// irq is registered, one cycle behind the status.
//--------------------------------------------------------------------
module ttc_intr_ctrl (
  input  logic               pclk11,
  input  logic               n_p_reset11,
  input  ttc_pkg::reg_wr_t   reg_wr,
  input  ttc_pkg::intr_evt_t evt,
  input  logic               isr_rd_clr,
  output ttc_pkg::intr_evt_t isr,
  output ttc_pkg::intr_evt_t ier,
  output logic               irq
);

  import ttc_pkg::*;

  intr_evt_t        isr_prev;          // Status as sampled by the read
  logic [EVT_W-1:0] clr_mask;
  logic [EVT_W-1:0] isr_masked;

  assign clr_mask   = isr_rd_clr ? isr_prev : '0;
  assign isr_masked = isr & ier;

  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      isr      <= '0;
      isr_prev <= '0;
      ier      <= '0;
      irq      <= 1'b0;
    end
    else
    begin
      // Event wins over clear in the same cycle
      isr      <= intr_evt_t'((isr & ~clr_mask) | evt);
      isr_prev <= isr;
      if (reg_wr.ier)
        ier <= intr_evt_t'(reg_wr.wdata[EVT_W-1:0]);
      irq <= |isr_masked;
    end
  end

  // No stale interrupt once the masked status is empty
  a_irq_drop: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
    (isr_masked == '0) |=> !irq);

endmodule

//--- ttc_counter.sv
//--------------------------------------------------------------------
// Up/down counter with interval or full-range wrap and 3 matches.
// Interval is assumed static while the counter runs.
// Restart takes effect on a count_en cycle and then clears itself.
//--------------------------------------------------------------------
module ttc_counter (
  input  logic               pclk11,
  input  logic               n_p_reset11,
  input  ttc_pkg::reg_wr_t   reg_wr,
  input  logic               count_en,
  output ttc_pkg::cnt_view_t cnt_view,
  output ttc_pkg::intr_evt_t evt
);

  import ttc_pkg::*;

  cnt_ctrl_t        ctrl;
  logic [CNT_W-1:0] interval;
  logic [CNT_W-1:0] match1;
  logic [CNT_W-1:0] match2;
  logic [CNT_W-1:0] match3;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] start_val;         // Load value on restart
  logic [CNT_W-1:0] next_count;
  logic             counting;          // Counted since last restart
  logic             restart_temp;      // Restart was applied
  logic             evt_ok;

  assign cnt_view = '{count:    count,
                      ctrl:     ctrl,
                      interval: interval,
                      match1:   match1,
                      match2:   match2,
                      match3:   match3};

  //------------------------------------------------------------------
  // Register writes
  //------------------------------------------------------------------
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      ctrl     <= CNT_CTRL_RST;
      interval <= '0;
      match1   <= '0;
      match2   <= '0;
      match3   <= '0;
    end
    else
    begin
      if (reg_wr.ctrl)
        ctrl <= cnt_ctrl_t'(reg_wr.wdata[CTRL_W-1:0]);
      else if (restart_temp)
        ctrl.restart <= 1'b0;          // Drop the bit once applied
      if (reg_wr.interval)
        interval <= reg_wr.wdata;
      if (reg_wr.match1)
        match1 <= reg_wr.wdata;
      if (reg_wr.match2)
        match2 <= reg_wr.wdata;
      if (reg_wr.match3)
        match3 <= reg_wr.wdata;
    end
  end

  // Start value per mode
  always_comb
  begin
    if (!ctrl.decrement)
      start_val = CNT_ZERO;
    else if (ctrl.interval_mode)
      start_val = interval;
    else
      start_val = CNT_MAX;
  end

  // Next count with natural full-range wrap
  always_comb
  begin
    if (ctrl.interval_mode && ctrl.decrement)
      next_count = (count == CNT_ZERO) ? interval : count - 1'b1;
    else if (ctrl.interval_mode)
      next_count = (count == interval) ? CNT_ZERO : count + 1'b1;
    else if (ctrl.decrement)
      next_count = count - 1'b1;       // 0 -> FFFF
    else
      next_count = count + 1'b1;       // FFFF -> 0
  end

  //------------------------------------------------------------------
  // Counter
  //------------------------------------------------------------------
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      count        <= '0;
      counting     <= 1'b0;
      restart_temp <= 1'b0;
    end
    else if (count_en)
    begin
      if (ctrl.restart)
      begin
        count        <= start_val;
        counting     <= 1'b0;
        restart_temp <= 1'b1;
      end
      else
      begin
        if (!ctrl.disable_n)
        begin
          count    <= next_count;
          counting <= 1'b1;
        end
        restart_temp <= 1'b0;
      end
    end
  end

  // Events straight from the registered count
  assign evt_ok       = counting && !ctrl.disable_n && !ctrl.restart;
  assign evt.interval = ctrl.interval_mode && (count == CNT_ZERO) && evt_ok;
  assign evt.overflow = !ctrl.interval_mode && (count == CNT_ZERO) && evt_ok;
  assign evt.match1   = ctrl.match_mode && (count == match1) && evt_ok;
  assign evt.match2   = ctrl.match_mode && (count == match2) && evt_ok;
  assign evt.match3   = ctrl.match_mode && (count == match3) && evt_ok;

  // Interval increment never runs past the interval
  a_ival_bound: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
    (counting && ctrl.interval_mode && !ctrl.decrement && !ctrl.restart)
    |-> (count <= interval));

endmodule

//--- ttc_prescaler.sv
//--------------------------------------------------------------------
// Clock control register and count-enable divider.
// Ratio is 2^(ps_value+1) when ps_en is set, else enable every cycle.
// Any write to CLK_CTRL restarts the divider.
//--------------------------------------------------------------------
module ttc_prescaler (
  input  logic               pclk11,
  input  logic               n_p_reset11,
  input  ttc_pkg::reg_wr_t   reg_wr,
  output ttc_pkg::clk_ctrl_t clk_ctrl,
  output logic               count_en
);

  import ttc_pkg::*;

  logic [CNT_W-1:0] div_cnt;
  logic [CNT_W-1:0] div_term;          // Terminal value, ratio minus one

  // Low ps_value+1 bits set
  assign div_term = ~({CNT_W{1'b1}} << (clk_ctrl.ps_value + 5'd1));
  assign count_en = clk_ctrl.ps_en ? (div_cnt == div_term) : 1'b1;

  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      clk_ctrl <= '0;
      div_cnt  <= '0;
    end
    else if (reg_wr.clk)
    begin
      clk_ctrl <= clk_ctrl_t'(reg_wr.wdata[CLK_W-1:0]);
      div_cnt  <= '0;                  // Fresh start on new setting
    end
    else if (count_en)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // Divided enable is a single-cycle pulse
  a_en_pulse: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
    (clk_ctrl.ps_en && count_en) |=> (!count_en || !clk_ctrl.ps_en));

endmodule

//--- ttc_wb_regs.sv
//--------------------------------------------------------------------
// Wishbone classic slave, no wait states, no back-pressure.
// Master must hold cyc, stb, we, adr and dat_i until ack.
// Ack lasts one cycle, so a held stb gets one ack every two cycles.
//--------------------------------------------------------------------
module ttc_wb_regs (
  input  logic                       pclk11,
  input  logic                       n_p_reset11,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [ttc_pkg::ADR_W-1:0]  wb_adr,
  input  logic [ttc_pkg::CNT_W-1:0]  wb_dat_i,
  output logic [ttc_pkg::CNT_W-1:0]  wb_dat_o,
  output logic                       wb_ack,
  output ttc_pkg::reg_wr_t           reg_wr,
  output logic                       isr_rd_clr,
  input  ttc_pkg::cnt_view_t         cnt_view,
  input  ttc_pkg::clk_ctrl_t         clk_ctrl,
  input  ttc_pkg::intr_evt_t         isr,
  input  ttc_pkg::intr_evt_t         ier
);

  import ttc_pkg::*;

  wb_state_e        state;
  reg_addr_e        adr_q;             // Address held for the ack cycle
  logic             we_q;
  logic             req;               // New access sampled in idle
  logic [CNT_W-1:0] rd_mux;

  assign req    = (state == WB_IDLE) && wb_cyc && wb_stb;
  assign wb_ack = (state == WB_ACK);

  //------------------------------------------------------------------
  // Handshake FSM
  //------------------------------------------------------------------
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      state <= WB_IDLE;
      we_q  <= 1'b0;
    end
    else
    begin
      case (state)
        WB_IDLE:
        begin
          if (wb_cyc && wb_stb)
          begin
            state <= WB_ACK;
            we_q  <= wb_we;
          end
        end
        WB_ACK:  state <= WB_IDLE;   // Always back to idle
        default: state <= WB_IDLE;
      endcase
    end
  end

  // Address and read data, loaded at the sampling edge
  always_ff @(posedge pclk11)
  begin
    if (req)
    begin
      adr_q    <= reg_addr_e'(wb_adr);
      wb_dat_o <= rd_mux;              // Valid through the ack cycle
    end
  end

  //------------------------------------------------------------------
  // Read mux, zero extended, unmapped reads zero
  //------------------------------------------------------------------
  always_comb
  begin
    rd_mux = '0;
    case (wb_adr)
      CLK_CTRL: rd_mux = {{(CNT_W-CLK_W){1'b0}}, clk_ctrl};
      CNT_CTRL: rd_mux = {{(CNT_W-CTRL_W){1'b0}}, cnt_view.ctrl};
      COUNT:    rd_mux = cnt_view.count;
      INTERVAL: rd_mux = cnt_view.interval;
      MATCH1:   rd_mux = cnt_view.match1;
      MATCH2:   rd_mux = cnt_view.match2;
      MATCH3:   rd_mux = cnt_view.match3;
      ISR:      rd_mux = {{(CNT_W-EVT_W){1'b0}}, isr};
      IER:      rd_mux = {{(CNT_W-EVT_W){1'b0}}, ier};
      default:  rd_mux = '0;
    endcase
  end

  // Write strobes and read clear, only in the ack cycle
  always_comb
  begin
    reg_wr       = '0;
    reg_wr.wdata = wb_dat_i;           // Still held by the master
    isr_rd_clr   = 1'b0;
    if (wb_ack)
    begin
      if (we_q)
      begin
        case (adr_q)
          CLK_CTRL: reg_wr.clk      = 1'b1;
          CNT_CTRL: reg_wr.ctrl     = 1'b1;
          INTERVAL: reg_wr.interval = 1'b1;
          MATCH1:   reg_wr.match1   = 1'b1;
          MATCH2:   reg_wr.match2   = 1'b1;
          MATCH3:   reg_wr.match3   = 1'b1;
          IER:      reg_wr.ier      = 1'b1;
          default:  reg_wr.ier      = 1'b0;   // Read-only or unmapped
        endcase
      end
      else if (adr_q == ISR)
        isr_rd_clr = 1'b1;
    end
  end

  // One ack per access, never back to back
  a_ack_single: assert property (@(posedge pclk11) disable iff (!n_p_reset11)
    wb_ack |=> !wb_ack);

endmodule

//--- ttc_pkg.sv
//--------------------------------------------------------------------
// Shared types for one timer/counter channel on Wishbone classic.
// All accesses are full 16-bit words, with no byte selects.
// Unmapped word addresses read as zero and ignore writes.
//--------------------------------------------------------------------
package ttc_pkg;

  localparam int CNT_W  = 16;          // Counter and bus data width
  localparam int ADR_W  = 4;           // Word address width
  localparam int CTRL_W = 5;           // Counter control word
  localparam int CLK_W  = 5;           // Prescaler control word
  localparam int EVT_W  = 5;           // Event, ISR and IER width

  localparam logic [CNT_W-1:0] CNT_ZERO = '0;
  localparam logic [CNT_W-1:0] CNT_MAX  = '1;   // Full-range wrap value

  // Word address map
  typedef enum logic [ADR_W-1:0] {
    CLK_CTRL = 4'd0,
    CNT_CTRL = 4'd1,
    COUNT    = 4'd2,                   // Read only
    INTERVAL = 4'd3,
    MATCH1   = 4'd4,
    MATCH2   = 4'd5,
    MATCH3   = 4'd6,
    ISR      = 4'd7,                   // Read only, clears on read
    IER      = 4'd8
  } reg_addr_e;

  // Counter control, bit 0 at the bottom
  typedef struct packed {
    logic restart;                     // Self clearing
    logic match_mode;
    logic decrement;
    logic interval_mode;               // 0 means full-range overflow
    logic disable_n;                   // High stops the counter
  } cnt_ctrl_t;

  localparam cnt_ctrl_t CNT_CTRL_RST = 5'b00001;   // Disabled out of reset

  // Prescaler control
  typedef struct packed {
    logic [3:0] ps_value;              // Divide by 2^(ps_value+1)
    logic       ps_en;
  } clk_ctrl_t;

  // One strobe per writable register, plus the write data
  typedef struct packed {
    logic             clk;
    logic             ctrl;
    logic             interval;
    logic             match1;
    logic             match2;
    logic             match3;
    logic             ier;
    logic [CNT_W-1:0] wdata;
  } reg_wr_t;

  // Counter readback
  typedef struct packed {
    logic [CNT_W-1:0] count;
    cnt_ctrl_t        ctrl;
    logic [CNT_W-1:0] interval;
    logic [CNT_W-1:0] match1;
    logic [CNT_W-1:0] match2;
    logic [CNT_W-1:0] match3;
  } cnt_view_t;

  // Events, also the ISR and IER layout
  typedef struct packed {
    logic match3;
    logic match2;
    logic match1;
    logic overflow;
    logic interval;                    // Bit 0
  } intr_evt_t;

  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_e;

endpackage
